/* include/ex_defs.svh */
// Execute stage width definitions

`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////////////////////////

// Register and operand word
`define EX_XLEN 32

// Register file address, covers integer and spare upper half
`define EX_RADDR_W 6

//////////////////////////////////////////////////////////////////////
// Control widths
//////////////////////////////////////////////////////////////////////

// Operator word shared by ALU and multiplier
`define EX_OP_W 4

// Shift amount field taken from operand B
`define EX_SHAMT_W 5

`endif

/* design/ex_pkg.sv */
// Execute stage operator types

`include "ex_defs.svh"

package ex_pkg;

  // ALU view of the operator word
  typedef enum logic [`EX_OP_W-1:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    // Branch compares
    ALU_EQ   = 4'ha,
    ALU_NE   = 4'hb,
    ALU_LT   = 4'hc,
    ALU_GE   = 4'hd,
    ALU_LTU  = 4'he,
    ALU_GEU  = 4'hf
  } ex_alu_op_e;

  // Multiplier view of the operator word
  // Signed mode bit 0 marks A signed, bit 1 marks B signed
  typedef struct packed {
    logic       high;
    logic [1:0] signed_mode;
    logic       rsvd;
  } ex_mult_op_t;

  // One operator word, decoded by whichever unit is enabled
  typedef union packed {
    ex_alu_op_e  alu;
    ex_mult_op_t mult;
  } ex_op_u;

endpackage

/* design/ex_result_if.sv */
// Unit result bundle

`include "ex_defs.svh"

interface ex_result_if;

  // ALU side
  logic [`EX_XLEN-1:0] alu_result;
  logic                alu_cmp;

  // Multiplier side, ready low while the upper word is computed
  logic [`EX_XLEN-1:0] mult_result;
  logic                mult_ready;

  // Producers
  modport alu_src  (output alu_result, output alu_cmp);
  modport mult_src (output mult_result, output mult_ready);

  // Result select and stall logic
  modport sink (
    input alu_result,
    input alu_cmp,
    input mult_result,
    input mult_ready
  );

endinterface

/* design/ex_alu.sv */
// Integer ALU and branch compare

`include "ex_defs.svh"

module ex_alu import ex_pkg::*; (
  input  ex_op_u              op_i,
  input  logic [`EX_XLEN-1:0] operand_a_i,
  input  logic [`EX_XLEN-1:0] operand_b_i,
  ex_result_if.alu_src        res
);

  logic [`EX_SHAMT_W-1:0] shamt;
  logic                   lt_s;
  logic                   lt_u;
  logic                   cmp;
  logic [`EX_XLEN-1:0]    result;

  // Shift amount from low five bits of B
  assign shamt = operand_b_i[`EX_SHAMT_W-1:0];

  // Shared less-than comparators
  assign lt_s = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_u = operand_a_i < operand_b_i;

  // Compare outcome, zero for arithmetic and logic ops
  always_comb begin
    case (op_i.alu)
      ALU_SLT, ALU_LT:   cmp = lt_s;
      ALU_SLTU, ALU_LTU: cmp = lt_u;
      ALU_EQ:            cmp = (operand_a_i == operand_b_i);
      ALU_NE:            cmp = (operand_a_i != operand_b_i);
      ALU_GE:            cmp = ~lt_s;
      ALU_GEU:           cmp = ~lt_u;
      default:           cmp = 1'b0;
    endcase
  end

  // Result word
  always_comb begin
    case (op_i.alu)
      ALU_ADD: result = operand_a_i + operand_b_i;
      ALU_SUB: result = operand_a_i - operand_b_i;
      ALU_AND: result = operand_a_i & operand_b_i;
      ALU_OR:  result = operand_a_i | operand_b_i;
      ALU_XOR: result = operand_a_i ^ operand_b_i;
      ALU_SLL: result = operand_a_i << shamt;
      ALU_SRL: result = operand_a_i >> shamt;
      ALU_SRA: result = $unsigned($signed(operand_a_i) >>> shamt);
      // Set and compare ops give 0 or 1
      default: result = {{(`EX_XLEN-1){1'b0}}, cmp};
    endcase
  end

  assign res.alu_result = result;
  assign res.alu_cmp    = cmp;

endmodule

/* design/ex_mult.sv */
// Integer multiplier

`include "ex_defs.svh"

module ex_mult import ex_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                enable_i,
  input  ex_op_u              op_i,
  input  logic [`EX_XLEN-1:0] operand_a_i,
  input  logic [`EX_XLEN-1:0] operand_b_i,
  output logic                multicycle_o,
  ex_result_if.mult_src       res
);

  logic [`EX_XLEN:0]       op_a_ext;
  logic [`EX_XLEN:0]       op_b_ext;
  logic [2*`EX_XLEN-1:0]   product;
  logic                    busy_q;
  logic [`EX_XLEN-1:0]     high_q;

  //////////////////////////////////////////////////////////////////////
  // Operand extension and product
  //////////////////////////////////////////////////////////////////////

  // Sign bit only where the mode marks that operand as signed
  assign op_a_ext = {op_i.mult.signed_mode[0] & operand_a_i[`EX_XLEN-1], operand_a_i};
  assign op_b_ext = {op_i.mult.signed_mode[1] & operand_b_i[`EX_XLEN-1], operand_b_i};

  // 33 by 33 signed product covers all three upper-word variants
  assign product = $signed(op_a_ext) * $signed(op_b_ext);

  //////////////////////////////////////////////////////////////////////
  // Upper-word sequencing
  //////////////////////////////////////////////////////////////////////

  // First enabled cycle of an upper-word op
  assign multicycle_o = enable_i & op_i.mult.high & ~busy_q;

  // Second cycle shows the registered word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= multicycle_o;
    end
  end

  // Upper word captured in the first cycle
  always_ff @(posedge clk) begin
    if (multicycle_o) begin
      high_q <= product[2*`EX_XLEN-1:`EX_XLEN];
    end
  end

  // Low word goes straight out and MUL never stalls
  assign res.mult_result = busy_q ? high_q : product[`EX_XLEN-1:0];
  assign res.mult_ready  = ~multicycle_o;

endmodule

/* design/ex_fwd_mux.sv */
// Forwarding port select and stall logic

`include "ex_defs.svh"

module ex_fwd_mux (
  input  logic                   alu_en_i,
  input  logic                   mult_en_i,
  input  logic                   csr_access_i,
  input  logic                   lsu_en_i,
  input  logic [`EX_XLEN-1:0]    csr_rdata_i,
  input  logic                   regfile_alu_we_i,
  input  logic [`EX_RADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                   lsu_ready_ex_i,
  input  logic                   wb_ready_i,
  input  logic                   branch_in_ex_i,
  ex_result_if.sink              res,
  output logic                   regfile_alu_we_fw_o,
  output logic [`EX_RADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic [`EX_XLEN-1:0]    regfile_alu_wdata_fw_o,
  output logic                   ex_ready_o,
  output logic                   ex_valid_o
);

  logic units_ready;
  logic any_en;

  // Write port data, later matches override earlier ones
  always_comb begin
    regfile_alu_wdata_fw_o = '0;
    if (alu_en_i) begin
      regfile_alu_wdata_fw_o = res.alu_result;
    end
    if (mult_en_i) begin
      regfile_alu_wdata_fw_o = res.mult_result;
    end
    // CSR read data wins
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end
  end

  // Enable and address pass straight to the ID stage
  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  //////////////////////////////////////////////////////////////////////
  // Stall control
  //////////////////////////////////////////////////////////////////////

  assign units_ready = res.mult_ready & lsu_ready_ex_i & wb_ready_i;
  assign any_en      = alu_en_i | mult_en_i | csr_access_i | lsu_en_i;

  // Branches resolve here, so they bypass the downstream ready
  assign ex_ready_o = units_ready | branch_in_ex_i;
  assign ex_valid_o = any_en & units_ready;

endmodule

/* design/ex_wb_reg.sv */
// EX/WB load/store write port register

`include "ex_defs.svh"

module ex_wb_reg (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   ex_valid_i,
  input  logic                   wb_ready_i,
  input  logic                   lsu_err_i,
  input  logic                   regfile_we_i,
  input  logic [`EX_RADDR_W-1:0] regfile_waddr_i,
  output logic                   regfile_we_wb_o,
  output logic [`EX_RADDR_W-1:0] regfile_waddr_wb_o
);

  logic we_masked;

  // A faulting access never writes the register file
  assign we_masked = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_wb_o    <= 1'b0;
      regfile_waddr_wb_o <= '0;
    end else if (ex_valid_i) begin
      // Valid already implies WB ready
      regfile_we_wb_o <= we_masked;
      if (we_masked) begin
        regfile_waddr_wb_o <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // WB free but nothing arriving, flush the slot
      regfile_we_wb_o <= 1'b0;
    end
    // WB stalled, hold contents
  end

endmodule

/* design/ex_stage.sv */
// Execute stage top

`include "ex_defs.svh"

module ex_stage import ex_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,

  // Operator and ALU operands
  input  ex_op_u                 op_i,
  input  logic [`EX_XLEN-1:0]    alu_operand_a_i,
  input  logic [`EX_XLEN-1:0]    alu_operand_b_i,
  input  logic [`EX_XLEN-1:0]    alu_operand_c_i,
  input  logic                   alu_en_i,

  // Multiplier
  input  logic [`EX_XLEN-1:0]    mult_operand_a_i,
  input  logic [`EX_XLEN-1:0]    mult_operand_b_i,
  input  logic                   mult_en_i,
  output logic                   mult_multicycle_o,

  // CSR and load/store
  input  logic                   csr_access_i,
  input  logic [`EX_XLEN-1:0]    csr_rdata_i,
  input  logic                   lsu_en_i,
  input  logic [`EX_XLEN-1:0]    lsu_rdata_i,
  input  logic                   lsu_ready_ex_i,
  input  logic                   lsu_err_i,

  // From decode
  input  logic                   branch_in_ex_i,
  input  logic                   regfile_alu_we_i,
  input  logic [`EX_RADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                   regfile_we_i,
  input  logic [`EX_RADDR_W-1:0] regfile_waddr_i,

  // Forwarding port
  output logic                   regfile_alu_we_fw_o,
  output logic [`EX_RADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic [`EX_XLEN-1:0]    regfile_alu_wdata_fw_o,

  // Load/store write port
  output logic                   regfile_we_wb_o,
  output logic [`EX_RADDR_W-1:0] regfile_waddr_wb_o,
  output logic [`EX_XLEN-1:0]    regfile_wdata_wb_o,

  // To fetch
  output logic [`EX_XLEN-1:0]    jump_target_o,
  output logic                   branch_decision_o,

  // Stall control
  output logic                   ex_ready_o,
  output logic                   ex_valid_o,
  input  logic                   wb_ready_i
);

  ex_result_if res_if ();

  //////////////////////////////////////////////////////////////////////
  // Execute units
  //////////////////////////////////////////////////////////////////////

  ex_alu alu_inst (
    .op_i        (op_i),
    .operand_a_i (alu_operand_a_i),
    .operand_b_i (alu_operand_b_i),
    .res         (res_if.alu_src)
  );

  ex_mult mult_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .op_i         (op_i),
    .operand_a_i  (mult_operand_a_i),
    .operand_b_i  (mult_operand_b_i),
    .multicycle_o (mult_multicycle_o),
    .res          (res_if.mult_src)
  );

  //////////////////////////////////////////////////////////////////////
  // Result select and EX/WB register
  //////////////////////////////////////////////////////////////////////

  ex_fwd_mux fwd_mux_inst (
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .csr_rdata_i            (csr_rdata_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .wb_ready_i             (wb_ready_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .res                    (res_if.sink),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

  ex_wb_reg wb_reg_inst (
    .clk                (clk),
    .rst_n              (rst_n),
    .ex_valid_i         (ex_valid_o),
    .wb_ready_i         (wb_ready_i),
    .lsu_err_i          (lsu_err_i),
    .regfile_we_i       (regfile_we_i),
    .regfile_waddr_i    (regfile_waddr_i),
    .regfile_we_wb_o    (regfile_we_wb_o),
    .regfile_waddr_wb_o (regfile_waddr_wb_o)
  );

  // Load data goes to WB unregistered
  assign regfile_wdata_wb_o = lsu_rdata_i;

  // Branch target is operand C, decision from the ALU compare
  assign jump_target_o     = alu_operand_c_i;
  assign branch_decision_o = res_if.alu_cmp;

endmodule

/* bench/tb_clkgen.sv */
// Testbench clock and reset

module tb_clkgen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Free-running clock, low at time zero
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release lands on a falling edge, clear of the sampling edge
  initial begin
    rst_n_o = 1'b0;
    #(PERIOD_NS * RESET_CYCLES);
    rst_n_o = 1'b1;
  end

endmodule

/* bench/tb_ex_stage.sv */
// Execute stage testbench

`include "ex_defs.svh"

module tb_ex_stage import ex_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD_NS = 100;
  localparam int ALU_PAIRS     = 6;
  localparam int MULH_PAIRS    = 4;
  // Cycle budget of the reset, ALU, branch, multiplier, priority and EX/WB tests
  localparam int RUN_CYCLES      = 5 + 16 * ALU_PAIRS + 24 + 4 + 6 * MULH_PAIRS + 16 + 10;
  localparam int WATCHDOG_CYCLES = RUN_CYCLES + 50;

  logic                   clk;
  logic                   rst_n;
  ex_op_u                 op;
  logic [`EX_XLEN-1:0]    alu_a;
  logic [`EX_XLEN-1:0]    alu_b;
  logic [`EX_XLEN-1:0]    alu_c;
  logic [`EX_XLEN-1:0]    mult_a;
  logic [`EX_XLEN-1:0]    mult_b;
  logic [`EX_XLEN-1:0]    csr_rdata;
  logic [`EX_XLEN-1:0]    lsu_rdata;
  logic                   alu_en;
  logic                   mult_en;
  logic                   csr_access;
  logic                   lsu_en;
  logic                   lsu_ready_ex;
  logic                   lsu_err;
  logic                   branch_in_ex;
  logic                   wb_ready;
  logic                   regfile_alu_we;
  logic                   regfile_we;
  logic [`EX_RADDR_W-1:0] regfile_alu_waddr;
  logic [`EX_RADDR_W-1:0] regfile_waddr;
  logic                   mult_multicycle;
  logic                   regfile_alu_we_fw;
  logic                   regfile_we_wb;
  logic                   branch_decision;
  logic                   ex_ready;
  logic                   ex_valid;
  logic [`EX_RADDR_W-1:0] regfile_alu_waddr_fw;
  logic [`EX_RADDR_W-1:0] regfile_waddr_wb;
  logic [`EX_XLEN-1:0]    regfile_alu_wdata_fw;
  logic [`EX_XLEN-1:0]    regfile_wdata_wb;
  logic [`EX_XLEN-1:0]    jump_target;

  logic [31:0] seed = 32'hb511fc14;
  int          errors = 0;
  int          checks = 0;

  tb_clkgen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(3)) clkgen_inst (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ex_stage ex_stage_inst (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .op_i                   (op),
    .alu_operand_a_i        (alu_a),
    .alu_operand_b_i        (alu_b),
    .alu_operand_c_i        (alu_c),
    .alu_en_i               (alu_en),
    .mult_operand_a_i       (mult_a),
    .mult_operand_b_i       (mult_b),
    .mult_en_i              (mult_en),
    .mult_multicycle_o      (mult_multicycle),
    .csr_access_i           (csr_access),
    .csr_rdata_i            (csr_rdata),
    .lsu_en_i               (lsu_en),
    .lsu_rdata_i            (lsu_rdata),
    .lsu_ready_ex_i         (lsu_ready_ex),
    .lsu_err_i              (lsu_err),
    .branch_in_ex_i         (branch_in_ex),
    .regfile_alu_we_i       (regfile_alu_we),
    .regfile_alu_waddr_i    (regfile_alu_waddr),
    .regfile_we_i           (regfile_we),
    .regfile_waddr_i        (regfile_waddr),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw),
    .regfile_we_wb_o        (regfile_we_wb),
    .regfile_waddr_wb_o     (regfile_waddr_wb),
    .regfile_wdata_wb_o     (regfile_wdata_wb),
    .jump_target_o          (jump_target),
    .branch_decision_o      (branch_decision),
    .ex_ready_o             (ex_ready),
    .ex_valid_o             (ex_valid),
    .wb_ready_i             (wb_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // Random source and reference models
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Compare and set-less-than outcome
  function automatic logic cmp_model(ex_op_u op_w, logic [`EX_XLEN-1:0] a,
                                     logic [`EX_XLEN-1:0] b);
    logic signed [`EX_XLEN-1:0] sa;
    logic signed [`EX_XLEN-1:0] sb;
    sa = a;
    sb = b;
    case (op_w.alu)
      ALU_SLT, ALU_LT:   return sa < sb;
      ALU_SLTU, ALU_LTU: return a < b;
      ALU_EQ:            return a == b;
      ALU_NE:            return a != b;
      ALU_GE:            return sa >= sb;
      ALU_GEU:           return a >= b;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic logic [`EX_XLEN-1:0] alu_model(ex_op_u op_w, logic [`EX_XLEN-1:0] a,
                                                    logic [`EX_XLEN-1:0] b);
    logic signed [`EX_XLEN-1:0] sa;
    sa = a;
    case (op_w.alu)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      ALU_SRA: return sa >>> b[4:0];
      default: return {{(`EX_XLEN-1){1'b0}}, cmp_model(op_w, a, b)};
    endcase
  endfunction

  // Operands widened by their signed-mode bit and product taken modulo 2^64
  function automatic logic [`EX_XLEN-1:0] mult_model(ex_op_u op_w, logic [`EX_XLEN-1:0] a,
                                                     logic [`EX_XLEN-1:0] b);
    logic [2*`EX_XLEN-1:0] ea;
    logic [2*`EX_XLEN-1:0] eb;
    logic [2*`EX_XLEN-1:0] p;
    ea = {{`EX_XLEN{op_w.mult.signed_mode[0] & a[`EX_XLEN-1]}}, a};
    eb = {{`EX_XLEN{op_w.mult.signed_mode[1] & b[`EX_XLEN-1]}}, b};
    p  = ea * eb;
    return op_w.mult.high ? p[2*`EX_XLEN-1:`EX_XLEN] : p[`EX_XLEN-1:0];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input logic [`EX_XLEN-1:0] exp,
                            input logic [`EX_XLEN-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR t=%0t %s exp=%h act=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input logic [`EX_RADDR_W-1:0] exp,
                            input logic [`EX_RADDR_W-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR t=%0t %s exp=%h act=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR t=%0t %s exp=%b act=%b", $time, name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Drive helpers
  //////////////////////////////////////////////////////////////////////

  // Nothing enabled and downstream ready
  task automatic drive_idle();
    op                = '0;
    alu_a             = '0;
    alu_b             = '0;
    alu_c             = '0;
    mult_a            = '0;
    mult_b            = '0;
    csr_rdata         = '0;
    lsu_rdata         = '0;
    alu_en            = 1'b0;
    mult_en           = 1'b0;
    csr_access        = 1'b0;
    lsu_en            = 1'b0;
    lsu_ready_ex      = 1'b1;
    lsu_err           = 1'b0;
    branch_in_ex      = 1'b0;
    wb_ready          = 1'b1;
    regfile_alu_we    = 1'b0;
    regfile_we        = 1'b0;
    regfile_alu_waddr = '0;
    regfile_waddr     = '0;
  endtask

  // Drive point shortly after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  // Outputs stable well before the next edge
  task automatic settle();
    #30;
  endtask

  // Corner cases first and random pairs after
  task automatic pick_operands(input int idx, output logic [`EX_XLEN-1:0] a,
                               output logic [`EX_XLEN-1:0] b);
    a = next_rand();
    b = next_rand();
    case (idx)
      0:       a = 32'h8000_0000;
      // Bits above the shift field must be ignored
      1:       b = 32'h0000_003f;
      2:       b = a;
      3:       a = 32'hffff_ffff;
      4:       b = 32'h8000_0000;
      default: ;
    endcase
  endtask

  task automatic report_test(input string name, input int c0, input int e0);
    $display("%s: %0d checks, %0d errors", name, checks - c0, errors - e0);
  endtask

  task automatic check_reset_state();
    check_flag("regfile_we_wb_o", 1'b0, regfile_we_wb);
    check_addr("regfile_waddr_wb_o", '0, regfile_waddr_wb);
    check_flag("mult_multicycle_o", 1'b0, mult_multicycle);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    int c0;
    int e0;
    c0 = checks;
    e0 = errors;
    // First clock edge inside the reset window
    next_cycle();
    settle();
    check_reset_state();
    wait (rst_n === 1'b1);
    next_cycle();
    settle();
    check_reset_state();
    report_test("reset", c0, e0);
  endtask

  task automatic test_alu();
    int c0;
    int e0;
    c0 = checks;
    e0 = errors;
    for (int k = 0; k < 16; k++) begin
      for (int p = 0; p < ALU_PAIRS; p++) begin
        next_cycle();
        drive_idle();
        op.alu = ex_alu_op_e'(k);
        alu_en = 1'b1;
        pick_operands(p, alu_a, alu_b);
        alu_c = next_rand();
        settle();
        check_word("regfile_alu_wdata_fw_o", alu_model(op, alu_a, alu_b),
                   regfile_alu_wdata_fw);
        check_flag("ex_valid_o", 1'b1, ex_valid);
      end
    end
    report_test("alu_ops", c0, e0);
  endtask

  // Branch resolves while WB stalls
  task automatic test_branch();
    int c0;
    int e0;
    c0 = checks;
    e0 = errors;
    for (int k = 10; k < 16; k++) begin
      for (int p = 0; p < 4; p++) begin
        next_cycle();
        drive_idle();
        op.alu       = ex_alu_op_e'(k);
        alu_en       = 1'b1;
        branch_in_ex = 1'b1;
        wb_ready     = 1'b0;
        pick_operands(p, alu_a, alu_b);
        alu_c = next_rand();
        settle();
        check_flag("branch_decision_o", cmp_model(op, alu_a, alu_b), branch_decision);
        check_word("jump_target_o", alu_c, jump_target);
        check_flag("ex_ready_o", 1'b1, ex_ready);
        check_flag("ex_valid_o", 1'b0, ex_valid);
      end
    end
    report_test("branch", c0, e0);
  endtask

  task automatic test_mult();
    int          c0;
    int          e0;
    ex_mult_op_t mop;
    c0 = checks;
    e0 = errors;
    // Low word in a single cycle
    for (int p = 0; p < 4; p++) begin
      next_cycle();
      drive_idle();
      mult_en = 1'b1;
      pick_operands(p, mult_a, mult_b);
      settle();
      check_word("regfile_alu_wdata_fw_o", mult_model(op, mult_a, mult_b),
                 regfile_alu_wdata_fw);
      check_flag("mult_multicycle_o", 1'b0, mult_multicycle);
      check_flag("ex_valid_o", 1'b1, ex_valid);
    end
    // Upper-word variants MULHU, MULHSU and MULH
    for (int m = 0; m < 3; m++) begin
      for (int p = 0; p < MULH_PAIRS; p++) begin
        next_cycle();
        drive_idle();
        mop.high        = 1'b1;
        mop.signed_mode = (m == 2) ? 2'b11 : 2'(m);
        mop.rsvd        = 1'b0;
        op.mult         = mop;
        mult_en         = 1'b1;
        pick_operands(p, mult_a, mult_b);
        settle();
        check_flag("mult_multicycle_o", 1'b1, mult_multicycle);
        check_flag("ex_ready_o", 1'b0, ex_ready);
        check_flag("ex_valid_o", 1'b0, ex_valid);
        // Inputs held through the stall cycle
        next_cycle();
        settle();
        check_flag("mult_multicycle_o", 1'b0, mult_multicycle);
        check_flag("ex_ready_o", 1'b1, ex_ready);
        check_flag("ex_valid_o", 1'b1, ex_valid);
        check_word("regfile_alu_wdata_fw_o", mult_model(op, mult_a, mult_b),
                   regfile_alu_wdata_fw);
      end
    end
    report_test("mult", c0, e0);
  endtask

  // Sources dropped one per cycle in the order CSR, multiplier, ALU and none
  task automatic test_priority();
    int          c0;
    int          e0;
    logic [31:0] r;
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      next_cycle();
      drive_idle();
      r                 = next_rand();
      op                = ex_op_u'({1'b0, r[2:0]});
      alu_a             = next_rand();
      alu_b             = next_rand();
      mult_a            = next_rand();
      mult_b            = next_rand();
      csr_rdata         = next_rand();
      regfile_alu_we    = r[8];
      regfile_alu_waddr = r[21:16];
      alu_en            = 1'b1;
      mult_en           = 1'b1;
      csr_access        = 1'b1;
      settle();
      check_word("regfile_alu_wdata_fw_o", csr_rdata, regfile_alu_wdata_fw);
      check_flag("regfile_alu_we_fw_o", regfile_alu_we, regfile_alu_we_fw);
      check_addr("regfile_alu_waddr_fw_o", regfile_alu_waddr, regfile_alu_waddr_fw);
      next_cycle();
      csr_access = 1'b0;
      settle();
      check_word("regfile_alu_wdata_fw_o", mult_model(op, mult_a, mult_b),
                 regfile_alu_wdata_fw);
      next_cycle();
      mult_en = 1'b0;
      settle();
      check_word("regfile_alu_wdata_fw_o", alu_model(op, alu_a, alu_b), regfile_alu_wdata_fw);
      next_cycle();
      alu_en = 1'b0;
      settle();
      check_word("regfile_alu_wdata_fw_o", '0, regfile_alu_wdata_fw);
      check_flag("ex_valid_o", 1'b0, ex_valid);
    end
    report_test("priority", c0, e0);
  endtask

  task automatic test_wb_reg();
    int c0;
    int e0;
    c0 = checks;
    e0 = errors;
    // Valid write lands one cycle later
    next_cycle();
    drive_idle();
    alu_en        = 1'b1;
    regfile_we    = 1'b1;
    regfile_waddr = 6'h15;
    settle();
    check_flag("ex_valid_o", 1'b1, ex_valid);
    next_cycle();
    drive_idle();
    lsu_rdata = next_rand();
    settle();
    check_flag("regfile_we_wb_o", 1'b1, regfile_we_wb);
    check_addr("regfile_waddr_wb_o", 6'h15, regfile_waddr_wb);
    check_word("regfile_wdata_wb_o", lsu_rdata, regfile_wdata_wb);
    // Idle cycle flushed the slot
    next_cycle();
    settle();
    check_flag("regfile_we_wb_o", 1'b0, regfile_we_wb);
    check_addr("regfile_waddr_wb_o", 6'h15, regfile_waddr_wb);
    // Faulting access leaves the address untouched
    next_cycle();
    lsu_en        = 1'b1;
    lsu_err       = 1'b1;
    regfile_we    = 1'b1;
    regfile_waddr = 6'h2a;
    next_cycle();
    drive_idle();
    settle();
    check_flag("regfile_we_wb_o", 1'b0, regfile_we_wb);
    check_addr("regfile_waddr_wb_o", 6'h15, regfile_waddr_wb);
    // Write followed by a WB stall
    next_cycle();
    alu_en        = 1'b1;
    regfile_we    = 1'b1;
    regfile_waddr = 6'h3c;
    next_cycle();
    wb_ready      = 1'b0;
    regfile_waddr = 6'h07;
    settle();
    check_flag("ex_valid_o", 1'b0, ex_valid);
    check_flag("ex_ready_o", 1'b0, ex_ready);
    check_flag("regfile_we_wb_o", 1'b1, regfile_we_wb);
    check_addr("regfile_waddr_wb_o", 6'h3c, regfile_waddr_wb);
    next_cycle();
    drive_idle();
    wb_ready = 1'b0;
    settle();
    check_flag("regfile_we_wb_o", 1'b1, regfile_we_wb);
    check_addr("regfile_waddr_wb_o", 6'h3c, regfile_waddr_wb);
    // Still held until a ready edge flushes the slot
    next_cycle();
    wb_ready = 1'b1;
    settle();
    check_flag("regfile_we_wb_o", 1'b1, regfile_we_wb);
    next_cycle();
    settle();
    check_flag("regfile_we_wb_o", 1'b0, regfile_we_wb);
    report_test("wb_reg", c0, e0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    drive_idle();
    test_reset();
    test_alu();
    test_branch();
    test_mult();
    test_priority();
    test_wb_reg();
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

/* project.f */
+incdir+include
design/ex_pkg.sv
design/ex_result_if.sv
design/ex_alu.sv
design/ex_mult.sv
design/ex_fwd_mux.sv
design/ex_wb_reg.sv
design/ex_stage.sv
bench/tb_clkgen.sv
bench/tb_ex_stage.sv

/* Bender.yml */
package:
  name: ex_stage

export_include_dirs:
  - include

sources:
  - files:
      - design/ex_pkg.sv
      - design/ex_result_if.sv
      - design/ex_alu.sv
      - design/ex_mult.sv
      - design/ex_fwd_mux.sv
      - design/ex_wb_reg.sv
      - design/ex_stage.sv
  - target: test
    files:
      - bench/tb_clkgen.sv
      - bench/tb_ex_stage.sv
